// File: Bender.yml
package:
  name: icache

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/icache_addr_pkg.sv
      - src/icache_ctrl_pkg.sv
      - src/icache_tag_array.sv
      - src/icache_data_array.sv
      - src/icache_way_select.sv
      - src/icache_beat_counter.sv
      - src/icache_ctrl_fsm.sv
      - src/icache_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/icache_assert.sv
      - sim/icache_tb.sv

// File: sim/icache_assert.sv
// Handshake checks for the instruction cache top level
// Bound into icache_top and watching the request, response and memory ports
`timescale 1ns/100ps

module icache_assert (
	input logic clk,
	input logic rst,
	input logic req_ready_i,
	input logic rsp_valid_i,
	input logic rsp_ready_i,
	input icache_addr_pkg::word_t rsp_data_i,
	input logic mem_req_valid_i,
	input logic mem_req_ready_i,
	input icache_addr_pkg::address_t mem_req_adr_i
);

	// ==============================
	// Request and response
	// ==============================

	// Only one fetch is in flight, so the port stays shut while a word is offered
	ready_vs_rsp: assert property (@(posedge clk) disable iff (rst)
		!(req_ready_i && rsp_valid_i))
		else $error("req_ready_o and rsp_valid_o high in the same cycle");

	// A stalled response keeps both its valid and its word
	rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i))
		else $error("rsp_data_o changed or rsp_valid_o dropped while stalled");

	// ==============================
	// Memory side
	// ==============================

	// The line request and its address wait for memory to accept them
	mem_req_hold: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_adr_i))
		else $error("mem_req_valid_o or mem_req_adr_o changed before acceptance");

endmodule

bind icache_top icache_assert u_assert (
	.clk             (clk),
	.rst             (rst),
	.req_ready_i     (req_ready_o),
	.rsp_valid_i     (rsp_valid_o),
	.rsp_ready_i     (rsp_ready_i),
	.rsp_data_i      (rsp_data_o),
	.mem_req_valid_i (mem_req_valid_o),
	.mem_req_ready_i (mem_req_ready_i),
	.mem_req_adr_i   (mem_req_adr_o)
);

// File: sim/icache_tb.sv
// Testbench for the instruction cache lookup and refill path
// Applies a table of fetches against a line memory model and checks every response
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_tb;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 10;
	localparam int N_STIM       = 19;
	localparam int WATCHDOG_NS  = (N_STIM * 200 + RESET_CYCLES + `ICACHE_LINES) * CLK_PERIOD;

	// One fetch with the outcome the pseudo-LRU rule predicts for it
	typedef struct packed {
		icache_addr_pkg::address_t vadr;
		icache_addr_pkg::address_t padr;
		logic miss;
	} stim_t;

	logic clk;
	logic rst;
	logic req_valid_i;
	logic req_ready_o;
	icache_addr_pkg::address_t req_vadr_i;
	icache_addr_pkg::address_t req_padr_i;
	logic rsp_valid_o;
	logic rsp_ready_i;
	icache_addr_pkg::word_t rsp_data_o;
	logic mem_req_valid_o;
	logic mem_req_ready_i;
	icache_addr_pkg::address_t mem_req_adr_o;
	logic mem_rsp_valid_i;
	icache_addr_pkg::word_t mem_rsp_data_i;

	logic [31:0] lfsr_q = 32'h6fe970f4;
	int line_reqs = 0;
	icache_addr_pkg::address_t last_line_adr = '0;

	// Sets 1, 3 and 5 are kept apart so each group sees its own LRU history
	// In set 3 the fills go to ways 0, 2, 1, 3 and the fifth line takes way 0
	stim_t stim [N_STIM] = '{
		'{32'h0000_0110, 32'h0000_0110, 1'b1},
		'{32'h0000_0110, 32'h0000_0110, 1'b0},
		'{32'h0000_011c, 32'h0000_011c, 1'b0},
		'{32'h0000_1030, 32'h0000_1030, 1'b1},
		'{32'h0000_2034, 32'h0000_2034, 1'b1},
		'{32'h0000_3038, 32'h0000_3038, 1'b1},
		'{32'h0000_403c, 32'h0000_403c, 1'b1},
		'{32'h0000_5030, 32'h0000_5030, 1'b1},
		'{32'h0000_2030, 32'h0000_2030, 1'b0},
		'{32'h0000_1034, 32'h0000_1034, 1'b1},
		'{32'h0000_5038, 32'h0000_5038, 1'b0},
		'{32'h0000_303c, 32'h0000_303c, 1'b1},
		'{32'h0000_4030, 32'h0000_4030, 1'b1},
		'{32'h0000_2038, 32'h0000_2038, 1'b0},
		// Same virtual line moved to another physical line and back again
		'{32'h0000_6050, 32'h0000_6050, 1'b1},
		'{32'h0000_6054, 32'h0009_a054, 1'b1},
		'{32'h0000_6054, 32'h0009_a054, 1'b0},
		'{32'h0000_6050, 32'h0000_6050, 1'b1},
		'{32'h0000_6058, 32'h0000_6058, 1'b0}
	};

	icache_top uut (
		.clk             (clk),
		.rst             (rst),
		.req_valid_i     (req_valid_i),
		.req_ready_o     (req_ready_o),
		.req_vadr_i      (req_vadr_i),
		.req_padr_i      (req_padr_i),
		.rsp_valid_o     (rsp_valid_o),
		.rsp_ready_i     (rsp_ready_i),
		.rsp_data_o      (rsp_data_o),
		.mem_req_valid_o (mem_req_valid_o),
		.mem_req_ready_i (mem_req_ready_i),
		.mem_req_adr_o   (mem_req_adr_o),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.mem_rsp_data_i  (mem_rsp_data_i)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ==============================
	// Helpers
	// ==============================

	// Inputs change 1 ns after the edge and outputs are read at the same point
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic abort_run();
		$display("sim failed");
		$fatal(1, "run stopped at the first error");
	endtask

	// Taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic rand_bits(input int n, output int v);
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = (v << 1) | int'(lfsr_q[0]);
		end
	endtask

	task automatic drive_request(input int i);
		req_valid_i = 1'b1;
		req_vadr_i  = stim[i].vadr;
		req_padr_i  = stim[i].padr;
	endtask

	task automatic check_word(input string name, input icache_addr_pkg::word_t got,
		input icache_addr_pkg::word_t exp);
		if (got !== exp) begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_adr(input string name, input icache_addr_pkg::address_t got,
		input icache_addr_pkg::address_t exp);
		if (got !== exp) begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_miss(input string name, input bit got, input bit exp);
		if (got !== exp) begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_latency(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("mismatch %s got %h expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// ==============================
	// Memory model
	// ==============================

	// Word at byte address A is A xor 5a5a0000 and beats come back in address order
	initial begin : memory_model
		int delay;
		int gap;
		icache_addr_pkg::address_t line;

		mem_req_ready_i = 1'b0;
		mem_rsp_valid_i = 1'b0;
		mem_rsp_data_i  = '0;
		forever begin
			next_cycle();
			if (mem_req_valid_o) begin
				rand_bits(2, delay);
				repeat (delay) begin
					next_cycle();
					if (!mem_req_valid_o) begin
						$display("line request withdrawn before memory accepted it");
						abort_run();
					end
				end
				line = mem_req_adr_o;
				mem_req_ready_i = 1'b1;
				next_cycle();
				mem_req_ready_i = 1'b0;
				line_reqs++;
				last_line_adr = line;
				for (int b = 0; b < `ICACHE_BEATS; b++) begin
					rand_bits(2, gap);
					repeat (gap) next_cycle();
					mem_rsp_valid_i = 1'b1;
					mem_rsp_data_i  = (line + 32'(4 * b)) ^ 32'h5a5a_0000;
					next_cycle();
					mem_rsp_valid_i = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout, the table did not finish within %0d ns", WATCHDOG_NS);
		abort_run();
	end

	// ==============================
	// Stimulus and checks
	// ==============================

	initial begin : stimulus
		int sweep_cycles;
		int lat;
		int reqs_before;
		int ready_bit;
		icache_addr_pkg::word_t held_data;
		icache_addr_pkg::word_t exp_data;

		rst         = 1'b1;
		req_valid_i = 1'b0;
		req_vadr_i  = '0;
		req_padr_i  = '0;
		rsp_ready_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// The first fetch already waits while the valid bits are swept
		drive_request(0);
		sweep_cycles = 0;
		while (!req_ready_o) begin
			next_cycle();
			sweep_cycles++;
		end
		if (sweep_cycles < `ICACHE_LINES) begin
			$display("request port opened after only %0d sweep cycles", sweep_cycles);
			abort_run();
		end
		if (line_reqs != 0) begin
			$display("memory saw a line request during the reset sweep");
			abort_run();
		end

		for (int i = 0; i < N_STIM; i++) begin
			while (!req_ready_o)
				next_cycle();
			reqs_before = line_reqs;
			next_cycle();

			// The next fetch is offered at once and must wait for this response
			if (i + 1 < N_STIM)
				drive_request(i + 1);
			else
				req_valid_i = 1'b0;

			lat = 0;
			while (!rsp_valid_o) begin
				if (req_ready_o) begin
					$display("request port opened while fetch %0d was in flight", i);
					abort_run();
				end
				next_cycle();
				lat++;
			end

			// Under random back-pressure the word has to stay put until it is taken
			held_data = rsp_data_o;
			ready_bit = 0;
			while (ready_bit == 0) begin
				if (!rsp_valid_o || req_ready_o) begin
					$display("response of fetch %0d left before it was taken", i);
					abort_run();
				end
				check_word("rsp_data_o", rsp_data_o, held_data);
				rand_bits(1, ready_bit);
				rsp_ready_i = ready_bit[0];
				next_cycle();
			end
			rsp_ready_i = 1'b0;

			exp_data = {stim[i].padr[31:2], 2'b00} ^ 32'h5a5a_0000;
			check_word("rsp_data_o", held_data, exp_data);
			if (line_reqs - reqs_before > 1) begin
				$display("fetch %0d caused more than one line request", i);
				abort_run();
			end
			check_miss("line request", line_reqs != reqs_before, stim[i].miss);
			if (stim[i].miss)
				check_adr("mem_req_adr_o", last_line_adr, {stim[i].padr[31:4], 4'h0});
			else
				check_latency("rsp_valid_o latency", lat, 2);
		end

		$display("sim passed");
		$finish;
	end

endmodule

// File: src/icache_addr_pkg.sv
// Address types of the instruction cache
// The fetch address union lets one word be read flat or as its fields
`include "icache_defines.svh"

package icache_addr_pkg;

	// Field widths derived from the line geometry
	localparam int IDX_W  = $clog2(`ICACHE_LINES);
	localparam int WSEL_W = $clog2(`ICACHE_BEATS);
	localparam int TAG_W  = `ICACHE_ADDR_W - IDX_W - `ICACHE_OFS_W;

	typedef logic [`ICACHE_ADDR_W-1:0] address_t;
	typedef logic [31:0] word_t;
	typedef logic [IDX_W-1:0] index_t;
	typedef logic [TAG_W-1:0] cache_tag_t;

	// Field view of a fetch address, most significant field first
	typedef struct packed {
		cache_tag_t tag;
		index_t index;
		logic [WSEL_W-1:0] word_sel;
		logic [`ICACHE_OFS_W-WSEL_W-1:0] byte_sel;
	} fetch_fields_t;

	// Requests are decoded through the fields
	// The line address for memory is formed from the flat view
	typedef union packed {
		address_t flat;
		fetch_fields_t f;
	} fetch_adr_u;

endpackage

// File: src/icache_beat_counter.sv
// Shared counter of the instruction cache
// Walks the sets after reset and then counts the beats of each refill
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_beat_counter (
	input  logic clk,
	input  logic rst,
	input  logic clear_i,
	input  logic step_i,
	output logic [3:0] count_o,
	output logic last_o
);

	logic [3:0] count_q;

	// Set by a clear, so the run is one line of beats and not the set range
	logic line_run_q;

	// Reset starts the sweep run and a clear starts a refill run
	always_ff @(posedge clk) begin
		if (rst) begin
			count_q    <= 4'd0;
			line_run_q <= 1'b0;
		end else if (clear_i) begin
			count_q    <= 4'd0;
			line_run_q <= 1'b1;
		end else if (step_i) begin
			count_q <= count_q + 4'd1;
		end
	end

	assign count_o = count_q;

	// Terminal count depends on which run is in progress
	// Refill only looks at the low two bits which are the beat number
	assign last_o = line_run_q ? (count_q[1:0] == 2'(`ICACHE_BEATS - 1)) :
		(count_q == 4'(`ICACHE_LINES - 1));

endmodule

// File: src/icache_ctrl_fsm.sv
// Instruction cache controller
// Sequences the reset sweep, lookup, line request, refill and response
`timescale 1ns/100ps

module icache_ctrl_fsm (
	input  logic clk,
	input  logic rst,
	input  logic req_valid_i,
	input  logic rsp_ready_i,
	input  logic mem_req_ready_i,
	input  logic mem_rsp_valid_i,
	input  logic hit_i,
	input  logic last_i,
	output logic cnt_clear_o,
	output logic cnt_step_o,
	output logic sweep_o,
	output logic accept_o,
	output logic tag_wr_o,
	output logic data_wr_o,
	output logic touch_o,
	output logic req_ready_o,
	output logic mem_req_valid_o,
	output logic rsp_valid_o
);

	icache_ctrl_pkg::ctrl_state_e state_q;
	icache_ctrl_pkg::ctrl_state_e state_d;

	// High in the second cycle of LOOKUP, when the registered hit is valid
	logic look_q;

	logic beat;

	// ==============================
	// Next state
	// ==============================

	// A received beat of the refill
	assign beat = (state_q == icache_ctrl_pkg::REFILL) && mem_rsp_valid_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			icache_ctrl_pkg::SWEEP:
				if (last_i)
					state_d = icache_ctrl_pkg::IDLE;
			icache_ctrl_pkg::IDLE:
				if (req_valid_i)
					state_d = icache_ctrl_pkg::LOOKUP;
			// First cycle compares, second cycle decides
			icache_ctrl_pkg::LOOKUP:
				if (look_q)
					state_d = hit_i ? icache_ctrl_pkg::RESPOND : icache_ctrl_pkg::LINE_REQ;
			icache_ctrl_pkg::LINE_REQ:
				if (mem_req_ready_i)
					state_d = icache_ctrl_pkg::REFILL;
			icache_ctrl_pkg::REFILL:
				if (beat && last_i)
					state_d = icache_ctrl_pkg::RESPOND;
			// Waits here with the word held until the requester takes it
			icache_ctrl_pkg::RESPOND:
				if (rsp_ready_i)
					state_d = icache_ctrl_pkg::IDLE;
			default:
				state_d = icache_ctrl_pkg::SWEEP;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= icache_ctrl_pkg::SWEEP;
			look_q  <= 1'b0;
		end else begin
			state_q <= state_d;
			look_q  <= (state_q == icache_ctrl_pkg::LOOKUP) && !look_q;
		end
	end

	// ==============================
	// Outputs
	// ==============================

	// Handshake outputs come straight from the state
	assign req_ready_o     = (state_q == icache_ctrl_pkg::IDLE);
	assign mem_req_valid_o = (state_q == icache_ctrl_pkg::LINE_REQ);
	assign rsp_valid_o     = (state_q == icache_ctrl_pkg::RESPOND);

	assign accept_o = req_ready_o && req_valid_i;
	assign sweep_o  = (state_q == icache_ctrl_pkg::SWEEP);

	// Counter restarts while the line request waits so beat 0 lands at count 0
	assign cnt_clear_o = mem_req_valid_o;
	assign cnt_step_o  = sweep_o || beat;

	// Every beat goes to the data array and the last one also commits the tags
	assign data_wr_o = beat;
	assign tag_wr_o  = beat && last_i;

	// The set's LRU bits move only when the word is handed over
	assign touch_o = rsp_valid_o && rsp_ready_i;

endmodule

// File: src/icache_ctrl_pkg.sv
// Controller types of the instruction cache
// State encoding, way number and pseudo-LRU tree bits

package icache_ctrl_pkg;

	// Sweep runs once after reset and every request then starts from IDLE
	typedef enum logic [2:0] {
		SWEEP    = 3'd0,
		IDLE     = 3'd1,
		LOOKUP   = 3'd2,
		LINE_REQ = 3'd3,
		REFILL   = 3'd4,
		RESPOND  = 3'd5
	} ctrl_state_e;

	// One of four ways
	typedef logic [1:0] way_t;

	// Tree bits of one set
	// Bit 0 is the root, bit 1 covers ways 0 and 1, bit 2 covers ways 2 and 3
	typedef logic [2:0] plru_t;

endpackage

// File: src/icache_data_array.sv
// Instruction cache data array
// Four ways of line storage filled beat by beat and read one word at a time
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_data_array (
	input  logic clk,
	input  logic wr_i,
	input  icache_ctrl_pkg::way_t way_i,
	input  icache_addr_pkg::index_t index_i,
	input  logic [1:0] beat_i,
	input  icache_addr_pkg::word_t wdata_i,
	input  logic [1:0] word_sel_i,
	output icache_addr_pkg::word_t rdata_o
);

	// Way, then set, then word within the line
	icache_addr_pkg::word_t line_mem [4][`ICACHE_LINES][`ICACHE_BEATS];

	// ==============================
	// Refill write
	// ==============================

	// Beats arrive in order so the beat number is the word position
	always_ff @(posedge clk) begin
		if (wr_i)
			line_mem[way_i][index_i][beat_i] <= wdata_i;
	end

	// ==============================
	// Word read
	// ==============================

	// The way is the hit way once the line is present
	// During a refill it is the way being filled, so the word shows up
	// as soon as the tags are written
	assign rdata_o = line_mem[way_i][index_i][word_sel_i];

endmodule

// File: src/icache_defines.svh
// Instruction cache geometry macros
// Address width, set count and line shape shared by packages and storage blocks
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ==============================
// Address
// ==============================

// Width of both the virtual and the physical fetch address
`define ICACHE_ADDR_W 32

// ==============================
// Line geometry
// ==============================

// Number of sets in each of the four ways
`define ICACHE_LINES 16

// Byte offset bits inside one line of 16 bytes
`define ICACHE_OFS_W 4

// Words per line and so also the number of refill beats
`define ICACHE_BEATS 4

`endif

// File: src/icache_tag_array.sv
// Instruction cache tag array
// Virtual and physical tag per set and way with a valid bit per line
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_tag_array (
	input  logic clk,
	input  logic rst,
	input  icache_addr_pkg::index_t index_i,
	input  logic sweep_i,
	input  logic wr_i,
	input  icache_ctrl_pkg::way_t wr_way_i,
	input  icache_addr_pkg::cache_tag_t vtag_i,
	input  icache_addr_pkg::cache_tag_t ptag_i,
	output icache_addr_pkg::cache_tag_t [3:0] vtags_o,
	output icache_addr_pkg::cache_tag_t [3:0] ptags_o,
	output logic [3:0] valid_o
);

	// Tag storage is small and read asynchronously so it maps to LUT memory
	icache_addr_pkg::cache_tag_t vtag_mem [4][`ICACHE_LINES];
	icache_addr_pkg::cache_tag_t ptag_mem [4][`ICACHE_LINES];

	// Valid bits live in flops with one nibble per set
	logic [3:0] valid_q [`ICACHE_LINES];

	// ==============================
	// Tag write
	// ==============================

	// Both tags of the refilled way are stored together on the last beat
	always_ff @(posedge clk) begin
		if (wr_i) begin
			vtag_mem[wr_way_i][index_i] <= vtag_i;
			ptag_mem[wr_way_i][index_i] <= ptag_i;
		end
	end

	// The sweep drops a whole set while a write marks one way as present
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `ICACHE_LINES; s++)
				valid_q[s] <= 4'b0000;
		end else if (sweep_i) begin
			valid_q[index_i] <= 4'b0000;
		end else if (wr_i) begin
			valid_q[index_i][wr_way_i] <= 1'b1;
		end
	end

	// ==============================
	// Read
	// ==============================

	// All four ways are presented at once for the compare
	always_comb begin
		for (int w = 0; w < 4; w++) begin
			vtags_o[w] = vtag_mem[w][index_i];
			ptags_o[w] = ptag_mem[w][index_i];
		end
	end

	assign valid_o = valid_q[index_i];

endmodule

// File: src/icache_top.sv
// Instruction cache lookup and refill path
// 4-way set-associative with virtual and physical tags per line
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_top (
	input  logic clk,
	input  logic rst,
	input  logic req_valid_i,
	output logic req_ready_o,
	input  icache_addr_pkg::address_t req_vadr_i,
	input  icache_addr_pkg::address_t req_padr_i,
	output logic rsp_valid_o,
	input  logic rsp_ready_i,
	output icache_addr_pkg::word_t rsp_data_o,
	output logic mem_req_valid_o,
	input  logic mem_req_ready_i,
	output icache_addr_pkg::address_t mem_req_adr_o,
	input  logic mem_rsp_valid_i,
	input  icache_addr_pkg::word_t mem_rsp_data_i
);

	icache_addr_pkg::fetch_adr_u vadr_q;
	icache_addr_pkg::fetch_adr_u padr_q;
	icache_addr_pkg::index_t arr_index;
	icache_addr_pkg::cache_tag_t [3:0] vtags;
	icache_addr_pkg::cache_tag_t [3:0] ptags;
	logic [3:0] valid;
	icache_ctrl_pkg::way_t way;
	logic [3:0] cnt;
	logic cnt_last;
	logic cnt_clear;
	logic cnt_step;
	logic sweep;
	logic accept;
	logic tag_wr;
	logic data_wr;
	logic touch;
	logic hit;

	// ==============================
	// Request register
	// ==============================

	// Holds the one request in flight until its response transfers
	always_ff @(posedge clk) begin
		if (accept) begin
			vadr_q.flat <= req_vadr_i;
			padr_q.flat <= req_padr_i;
		end
	end

	// Line-aligned physical address for the memory side
	assign mem_req_adr_o = {padr_q.flat[`ICACHE_ADDR_W-1:`ICACHE_OFS_W], {`ICACHE_OFS_W{1'b0}}};

	// Sets are virtually indexed and the sweep walks them with the counter
	assign arr_index = sweep ? icache_addr_pkg::index_t'(cnt) : vadr_q.f.index;

	// ==============================
	// Blocks
	// ==============================

	icache_tag_array u_tags (
		.clk      (clk),
		.rst      (rst),
		.index_i  (arr_index),
		.sweep_i  (sweep),
		.wr_i     (tag_wr),
		.wr_way_i (way),
		.vtag_i   (vadr_q.f.tag),
		.ptag_i   (padr_q.f.tag),
		.vtags_o  (vtags),
		.ptags_o  (ptags),
		.valid_o  (valid)
	);

	icache_data_array u_data (
		.clk        (clk),
		.wr_i       (data_wr),
		.way_i      (way),
		.index_i    (arr_index),
		.beat_i     (cnt[1:0]),
		.wdata_i    (mem_rsp_data_i),
		.word_sel_i (vadr_q.f.word_sel),
		.rdata_o    (rsp_data_o)
	);

	icache_way_select u_ways (
		.clk     (clk),
		.rst     (rst),
		.index_i (arr_index),
		.vtag_i  (vadr_q.f.tag),
		.ptag_i  (padr_q.f.tag),
		.vtags_i (vtags),
		.ptags_i (ptags),
		.valid_i (valid),
		.sweep_i (sweep),
		.touch_i (touch),
		.hit_o   (hit),
		.way_o   (way)
	);

	icache_beat_counter u_count (
		.clk     (clk),
		.rst     (rst),
		.clear_i (cnt_clear),
		.step_i  (cnt_step),
		.count_o (cnt),
		.last_o  (cnt_last)
	);

	icache_ctrl_fsm u_fsm (
		.clk             (clk),
		.rst             (rst),
		.req_valid_i     (req_valid_i),
		.rsp_ready_i     (rsp_ready_i),
		.mem_req_ready_i (mem_req_ready_i),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.hit_i           (hit),
		.last_i          (cnt_last),
		.cnt_clear_o     (cnt_clear),
		.cnt_step_o      (cnt_step),
		.sweep_o         (sweep),
		.accept_o        (accept),
		.tag_wr_o        (tag_wr),
		.data_wr_o       (data_wr),
		.touch_o         (touch),
		.req_ready_o     (req_ready_o),
		.mem_req_valid_o (mem_req_valid_o),
		.rsp_valid_o     (rsp_valid_o)
	);

endmodule

// File: src/icache_way_select.sv
// Way selection for the instruction cache
// Tag compare with synonym detection and a tree pseudo-LRU victim per set
`timescale 1ns/100ps
`include "icache_defines.svh"

module icache_way_select (
	input  logic clk,
	input  logic rst,
	input  icache_addr_pkg::index_t index_i,
	input  icache_addr_pkg::cache_tag_t vtag_i,
	input  icache_addr_pkg::cache_tag_t ptag_i,
	input  icache_addr_pkg::cache_tag_t [3:0] vtags_i,
	input  icache_addr_pkg::cache_tag_t [3:0] ptags_i,
	input  logic [3:0] valid_i,
	input  logic sweep_i,
	input  logic touch_i,
	output logic hit_o,
	output icache_ctrl_pkg::way_t way_o
);

	icache_ctrl_pkg::plru_t plru_q [`ICACHE_LINES];
	icache_ctrl_pkg::plru_t plru_set;
	logic [3:0] vmatch;
	logic [3:0] pmatch;
	logic [3:0] hit_vec;
	logic [3:0] syn_vec;
	icache_ctrl_pkg::way_t hit_way;
	icache_ctrl_pkg::way_t syn_way;
	icache_ctrl_pkg::way_t victim;
	logic hit_q;

	// ==============================
	// Compare
	// ==============================

	// A synonym is a present line reached by the same virtual tag
	// but mapped to another physical line
	always_comb begin
		for (int w = 0; w < 4; w++) begin
			vmatch[w]  = (vtags_i[w] == vtag_i);
			pmatch[w]  = (ptags_i[w] == ptag_i);
			hit_vec[w] = valid_i[w] & vmatch[w] & pmatch[w];
			syn_vec[w] = valid_i[w] & vmatch[w] & ~pmatch[w];
		end
	end

	// Lowest matching way wins, though at most one should match
	always_comb begin
		hit_way = 2'd0;
		syn_way = 2'd0;
		for (int w = 3; w >= 0; w--) begin
			if (hit_vec[w])
				hit_way = icache_ctrl_pkg::way_t'(w);
			if (syn_vec[w])
				syn_way = icache_ctrl_pkg::way_t'(w);
		end
	end

	// ==============================
	// Victim and way choice
	// ==============================

	assign plru_set = plru_q[index_i];

	// Root 0 picks the left pair, then a pair bit of 0 picks its lower way
	always_comb begin
		if (!plru_set[0])
			victim = {1'b0, plru_set[1]};
		else
			victim = {1'b1, plru_set[2]};
	end

	// A synonym line is overwritten in place so the set never holds
	// two lines with the same virtual tag
	assign way_o = (|hit_vec) ? hit_way : ((|syn_vec) ? syn_way : victim);

	// Touch turns the bits on the way's path away from it
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `ICACHE_LINES; s++)
				plru_q[s] <= '0;
		end else if (sweep_i) begin
			plru_q[index_i] <= '0;
		end else if (touch_i) begin
			plru_q[index_i][0] <= ~way_o[1];
			if (way_o[1])
				plru_q[index_i][2] <= ~way_o[0];
			else
				plru_q[index_i][1] <= ~way_o[0];
		end
	end

	// Hit is registered so the compare gets a cycle of its own
	always_ff @(posedge clk) begin
		if (rst)
			hit_q <= 1'b0;
		else
			hit_q <= |hit_vec;
	end

	assign hit_o = hit_q;

endmodule

// File: vlog.f
+incdir+src
src/icache_addr_pkg.sv
src/icache_ctrl_pkg.sv
src/icache_tag_array.sv
src/icache_data_array.sv
src/icache_way_select.sv
src/icache_beat_counter.sv
src/icache_ctrl_fsm.sv
src/icache_top.sv
sim/icache_assert.sv
sim/icache_tb.sv
